//--- bench/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	localparam int N_INSTR        = 400;
	localparam int RESET_CYCLES   = 16;
	localparam int DRAIN_CYCLES   = 8;
	localparam int TIMEOUT_CYCLES = N_INSTR * 2 + 100;
	localparam int ADDR_SLOTS     = 8;
	localparam int SLOT_STRIDE    = defines::MEM_WORDS / ADDR_SLOTS;
	localparam logic [31:0] SEED  = 32'h55c99e6b;

	logic clk;
	logic rst_n;
	logic instr_valid;
	defines::instr_t instr;
	defines::data_t pc;
	logic wb_valid;
	defines::reg_addr_t wb_rd;
	defines::data_t wb_data;

	defines::data_t model_regs [32];
	defines::data_t model_mem [defines::MEM_WORDS];
	logic mem_written [defines::MEM_WORDS];
	int stores_done;

	defines::reg_addr_t exp_rd_q [$];
	defines::data_t exp_data_q [$];
	int exp_cycle_q [$];

	int cycle_count = 0;
	int checked = 0;
	logic prev_load;
	defines::reg_addr_t prev_load_rd;

	exec_core i_exec_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) cycle_count <= cycle_count + 1;

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "run stopped at cycle %0d", cycle_count);
	endtask

	task automatic check_reg(input string name, input defines::reg_addr_t got,
			input defines::reg_addr_t exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input defines::data_t got,
			input defines::data_t exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic defines::reg_addr_t rand_reg();
		return defines::reg_addr_t'($urandom % 8); // small pool, many hazards
	endfunction

	function automatic int word_index(input defines::data_t addr);
		return (addr >> 2) % defines::MEM_WORDS;
	endfunction

	// rv32i integer semantics by funct3
	function automatic defines::data_t alu_ref(input logic [2:0] f3, input logic alt,
			input logic is_r, input defines::data_t a, input defines::data_t b);
		defines::data_t r;
		case (f3)
			3'b000: r = (is_r && alt) ? a - b : a + b;
			3'b001: r = a << b[4:0];
			3'b010: r = {31'b0, $signed(a) < $signed(b)};
			3'b011: r = {31'b0, a < b};
			3'b100: r = a ^ b;
			3'b101: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'b110: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic uses_load_rd(input defines::instr_t w);
		return prev_load && (w.rs1 == prev_load_rd ||
			(w.opcode != defines::STORE && w.rs2 == prev_load_rd));
	endfunction

	task automatic gen_instr(output defines::instr_t w);
		logic [31:0] raw;
		logic [11:0] off;
		int pick;
		int slot;
		raw = $urandom;
		w = raw;
		pick = $urandom % 16;
		if (prev_load && ($urandom % 2 == 0))
			pick = 16; // store of the word just loaded
		else if ((pick == 10 || pick == 11) && stores_done == 0)
			pick = 12;
		slot = $urandom % ADDR_SLOTS;
		if (pick == 10 || pick == 11) begin
			while (!mem_written[slot * SLOT_STRIDE])
				slot = $urandom % ADDR_SLOTS;
		end
		off = 12'(slot * SLOT_STRIDE * 4);
		w.rd = rand_reg();
		case (pick)
			0, 1, 2, 3: begin
				w.opcode = defines::R;
				w.rs1 = rand_reg();
				w.rs2 = rand_reg();
				w.funct7 = (raw[30] && (w.funct3 == 3'b000 || w.funct3 == 3'b101)) ? 7'h20 : 7'h00;
			end
			4, 5, 6: begin
				w.opcode = defines::I;
				w.rs1 = rand_reg();
				if (w.funct3 == 3'b001)
					w.funct7 = 7'h00;
				else if (w.funct3 == 3'b101)
					w.funct7 = raw[30] ? 7'h20 : 7'h00;
			end
			7: w.opcode = defines::LUI;
			8: w.opcode = defines::AUIPC;
			9: begin
				w.opcode = raw[0] ? defines::JAL : defines::JALR;
				if (!raw[0]) begin
					w.funct3 = 3'b000;
					w.rs1 = rand_reg();
				end
			end
			10, 11: begin
				w.opcode = defines::LOAD;
				w.funct3 = 3'b010;
				w.rs1 = '0;
				{w.funct7, w.rs2} = off;
			end
			12, 13, 16: begin
				w.opcode = defines::STORE;
				w.funct3 = 3'b010;
				w.rs1 = '0;
				w.rs2 = (pick == 16) ? prev_load_rd : rand_reg();
				w.funct7 = off[11:5];
				w.rd = off[4:0];
			end
			14: begin
				w.opcode = defines::B;
				w.rs1 = rand_reg();
				w.rs2 = rand_reg();
			end
			default: w.opcode = raw[1] ? defines::MEM : defines::SYS;
		endcase
	endtask

	task automatic model_execute(input defines::instr_t w, input defines::data_t pc_val,
			input int capture);
		logic [31:0] raw;
		defines::data_t imm_i, imm_s, imm_u, rs1_val, result;
		logic writes;
		raw = w;
		imm_i = {{20{raw[31]}}, raw[31:20]};
		imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
		imm_u = {raw[31:12], 12'b0};
		rs1_val = model_regs[w.rs1];
		writes = 1'b1;
		result = '0;
		case (w.opcode)
			defines::R:
				result = alu_ref(w.funct3, raw[30], 1'b1, rs1_val, model_regs[w.rs2]);
			defines::I:     result = alu_ref(w.funct3, raw[30], 1'b0, rs1_val, imm_i);
			defines::LUI:   result = imm_u;
			defines::AUIPC: result = pc_val + imm_u;
			defines::JAL, defines::JALR: result = pc_val + 4;
			defines::LOAD:  result = model_mem[word_index(rs1_val + imm_i)];
			defines::STORE: begin
				model_mem[word_index(rs1_val + imm_s)] = model_regs[w.rs2];
				mem_written[word_index(rs1_val + imm_s)] = 1'b1;
				stores_done++;
				writes = 1'b0;
			end
			default: writes = 1'b0; // b, fence, sys
		endcase
		if (writes && w.rd != '0) begin
			model_regs[w.rd] = result;
			exp_rd_q.push_back(w.rd);
			exp_data_q.push_back(result);
			exp_cycle_q.push_back(capture + 3);
		end
	endtask

	task automatic check_writeback();
		int due;
		if (wb_valid === 1'b1) begin
			if (exp_rd_q.size() == 0) begin
				$display("a writeback to x%0d appeared with no result expected", wb_rd);
				abort_run();
			end else begin
				due = exp_cycle_q.pop_front();
				check_reg("wb_rd", wb_rd, exp_rd_q.pop_front());
				check_data("wb_data", wb_data, exp_data_q.pop_front());
				if (cycle_count != due) begin
					$display("writeback to x%0d came at cycle %0d but was due at cycle %0d",
						wb_rd, cycle_count, due);
					abort_run();
				end else begin
					checked++;
				end
			end
		end else if (wb_valid !== 1'b0) begin
			$display("wb_valid is unknown at cycle %0d", cycle_count);
			abort_run();
		end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle_count) begin
			$display("the writeback to x%0d due at cycle %0d never appeared",
				exp_rd_q[0], exp_cycle_q[0]);
			abort_run();
		end
	endtask

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
		abort_run();
	end

	initial begin : stimulus
		defines::instr_t w;
		defines::data_t next_pc;
		next_pc = 32'h1000 + ($urandom(SEED) % 4096) * 4; // first draw seeds the generator
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		prev_load = 1'b0;
		prev_load_rd = '0;
		stores_done = 0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < defines::MEM_WORDS; i++)
			mem_written[i] = 1'b0;

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			if (wb_valid !== 1'b0) begin
				$display("wb_valid was not low while reset was held");
				abort_run();
			end
		end
		rst_n = 1'b1;

		for (int n = 0; n < N_INSTR; n++) begin
			@(negedge clk);
			check_writeback();
			if ($urandom % 4 == 0) begin // bubble
				instr_valid = 1'b0;
				instr = '0;
				prev_load = 1'b0;
				@(negedge clk);
				check_writeback();
			end
			do begin
				gen_instr(w);
			end while (uses_load_rd(w));
			instr_valid = 1'b1;
			instr = w;
			pc = next_pc;
			model_execute(w, next_pc, cycle_count + 1); // captured at the next edge
			prev_load = (w.opcode == defines::LOAD) && (w.rd != '0);
			prev_load_rd = w.rd;
			next_pc = next_pc + 4;
		end

		repeat (DRAIN_CYCLES) begin
			@(negedge clk);
			check_writeback();
			instr_valid = 1'b0;
			instr = '0;
		end

		if (exp_rd_q.size() != 0) begin
			$display("%0d expected writebacks still pending after the drain", exp_rd_q.size());
			abort_run();
		end else begin
			$display("%0d writebacks checked", checked);
			$display("Test OK");
			$finish;
		end
	end

endmodule

//--- project.f
source/defines.sv
source/decoder.sv
source/reg_file.sv
source/fwd_unit.sv
source/ex_mux.sv
source/alu.sv
source/data_mem.sv
source/exec_core.sv
bench/core_tb.sv

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
	input  defines::alu_op_t alu_op,
	input  defines::data_t   a,
	input  defines::data_t   b,
	output defines::data_t   result
);

	logic [4:0] shamt;
	logic lt_s, lt_u;

	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (alu_op)
			defines::ADD:    result = a + b;
			defines::SUB:    result = a - b;
			defines::SLL:    result = a << shamt;
			defines::SLT:    result = {31'b0, lt_s};
			defines::SLTU:   result = {31'b0, lt_u};
			defines::XOR:    result = a ^ b;
			defines::SRL:    result = a >> shamt;
			defines::SRA:    result = $signed(a) >>> shamt; // sign fill
			defines::OR:     result = a | b;
			defines::AND:    result = a & b;
			defines::PASS_B: result = b;
			default:         result = defines::NULL;
		endcase
	end

endmodule

//--- source/data_mem.sv
`timescale 1ns/1ps

module data_mem (
	input  logic           clk,
	input  defines::data_t addr,
	input  logic           wr_en,
	input  defines::data_t wr_data,
	output defines::data_t rd_data
);

	defines::data_t mem [defines::MEM_WORDS];
	logic [defines::MEM_AW-1:0] idx;

	assign idx     = addr[defines::MEM_AW+1:2]; // word index
	assign rd_data = mem[idx];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[idx] <= wr_data;
		end
	end

	a_wr_aligned: assert property (@(posedge clk) wr_en |-> addr[1:0] == 2'b00)
		else $error("misaligned store to %h", addr);

endmodule

//--- source/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  defines::instr_t  instr,
	output defines::data_t   imm,
	output defines::alu_op_t alu_op,
	output logic             writes_rd
);

	logic [31:0] raw;
	logic alt;

	assign raw = instr;
	assign alt = instr.funct7[5]; // sub / sra

	always_comb begin : imm_gen
		case (instr.opcode)
			defines::I, defines::LOAD:    imm = {{20{raw[31]}}, raw[31:20]};
			defines::STORE:               imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
			defines::LUI, defines::AUIPC: imm = {raw[31:12], 12'b0};
			defines::JAL, defines::JALR:  imm = 32'd4; // link is pc+4
			default:                      imm = defines::NULL;
		endcase
	end

	always_comb begin : op_gen
		alu_op = defines::PASS_B;
		case (instr.opcode)
			defines::R, defines::I: begin
				case (instr.funct3)
					defines::F3_ADD: begin
						if (instr.opcode == defines::R && alt)
							alu_op = defines::SUB;
						else
							alu_op = defines::ADD;
					end
					defines::F3_SLL:  alu_op = defines::SLL;
					defines::F3_SLT:  alu_op = defines::SLT;
					defines::F3_SLTU: alu_op = defines::SLTU;
					defines::F3_XOR:  alu_op = defines::XOR;
					defines::F3_SR:   alu_op = alt ? defines::SRA : defines::SRL;
					defines::F3_OR:   alu_op = defines::OR;
					defines::F3_AND:  alu_op = defines::AND;
					default:          alu_op = defines::ADD;
				endcase
			end
			defines::LUI, defines::AUIPC, defines::JAL, defines::JALR,
			defines::LOAD, defines::STORE: alu_op = defines::ADD;
			default: alu_op = defines::PASS_B; // b, fence, sys
		endcase
	end

	always_comb begin : wr_gen
		case (instr.opcode)
			defines::R, defines::I, defines::LUI, defines::AUIPC,
			defines::JAL, defines::JALR, defines::LOAD: writes_rd = (instr.rd != '0);
			default: writes_rd = 1'b0;
		endcase
	end

endmodule

//--- source/defines.sv
package defines;

	typedef logic [31:0] data_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes, rv32i base
	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111, // fence
		SYS   = 7'b1110011
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		opcode_t    opcode;
	} instr_t;

	typedef enum logic [1:0] {
		RS_SEL          = 2'b00,
		MEM_MEM_FWD_SEL = 2'b01,
		EX_EX_FWD_SEL   = 2'b10,
		MEM_EX_FWD_SEL  = 2'b11
	} fwd_sel_t;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASS_B
	} alu_op_t;

	localparam data_t NULL = '0;

	localparam int MEM_WORDS = 256;
	localparam int MEM_AW    = $clog2(MEM_WORDS);

	// funct3 of the R/I alu group
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

endpackage

//--- source/ex_mux.sv
`timescale 1ns/1ps

module ex_mux (
	input  defines::instr_t   instr,
	input  defines::data_t    pc,
	input  defines::data_t    rs1,
	input  defines::data_t    rs2,
	input  defines::data_t    imm,
	input  defines::data_t    ex_ex_fwd_data,
	input  defines::data_t    mem_ex_fwd_data,
	input  defines::fwd_sel_t fwd_a,
	input  defines::fwd_sel_t fwd_b,
	output defines::data_t    a_out,
	output defines::data_t    b_out,
	output defines::data_t    store_data
);

	typedef enum logic [1:0] {
		SRC_ZERO,
		SRC_REG,
		SRC_PC,
		SRC_IMM
	} src_t;

	src_t a_src, b_src;
	defines::data_t rs1_fwd, rs2_fwd;

	function automatic defines::data_t fwd_pick(
		input defines::fwd_sel_t sel,
		input defines::data_t    reg_val,
		input defines::data_t    ex_val,
		input defines::data_t    mem_val
	);
		case (sel)
			defines::EX_EX_FWD_SEL:  return ex_val;
			defines::MEM_EX_FWD_SEL: return mem_val;
			default:                 return reg_val; // mem-mem handled later
		endcase
	endfunction

	assign rs1_fwd = fwd_pick(fwd_a, rs1, ex_ex_fwd_data, mem_ex_fwd_data);
	assign rs2_fwd = fwd_pick(fwd_b, rs2, ex_ex_fwd_data, mem_ex_fwd_data);
	assign store_data = rs2_fwd;

	always_comb begin : src_ctrl
		a_src = SRC_ZERO;
		b_src = SRC_ZERO;
		case (instr.opcode)
			defines::R, defines::B: begin
				a_src = SRC_REG;
				b_src = SRC_REG;
			end
			defines::I, defines::LOAD, defines::STORE: begin // rs1 + imm
				a_src = SRC_REG;
				b_src = SRC_IMM;
			end
			defines::LUI: begin // 0 + imm
				a_src = SRC_ZERO;
				b_src = SRC_IMM;
			end
			defines::AUIPC, defines::JAL, defines::JALR: begin // pc + imm
				a_src = SRC_PC;
				b_src = SRC_IMM;
			end
			default: begin // fence, sys
				a_src = SRC_ZERO;
				b_src = SRC_ZERO;
			end
		endcase
	end

	always_comb begin : a_mux
		case (a_src)
			SRC_REG: a_out = rs1_fwd;
			SRC_PC:  a_out = pc;
			default: a_out = defines::NULL;
		endcase
	end

	always_comb begin : b_mux
		case (b_src)
			SRC_REG: b_out = rs2_fwd;
			SRC_IMM: b_out = imm;
			default: b_out = defines::NULL;
		endcase
	end

endmodule

//--- source/exec_core.sv
`timescale 1ns/1ps

module exec_core (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  defines::instr_t    instr,
	input  defines::data_t     pc,
	output logic               wb_valid,
	output defines::reg_addr_t wb_rd,
	output defines::data_t     wb_data
);

	defines::data_t id_imm, id_rs1, id_rs2;
	defines::alu_op_t id_alu_op;
	logic id_writes;

	logic id_ex_valid, id_ex_writes;
	defines::instr_t id_ex_instr;
	defines::data_t id_ex_pc, id_ex_rs1, id_ex_rs2, id_ex_imm;
	defines::alu_op_t id_ex_alu_op;
	defines::reg_addr_t id_ex_rd;

	defines::fwd_sel_t fwd_a, fwd_b;
	defines::data_t alu_a, alu_b, alu_result, ex_store_data;

	logic ex_mem_valid, ex_mem_writes, ex_mem_mm_fwd;
	defines::opcode_t ex_mem_opcode;
	defines::reg_addr_t ex_mem_rd;
	defines::data_t ex_mem_alu, ex_mem_store;

	logic mem_wr_en;
	defines::data_t mem_rd_data, mem_result, mem_wr_data;

	logic mem_wb_valid, mem_wb_writes;
	defines::reg_addr_t mem_wb_rd;
	defines::data_t mem_wb_result;

	decoder i_decoder (
		.instr     (instr),
		.imm       (id_imm),
		.alu_op    (id_alu_op),
		.writes_rd (id_writes)
	);

	reg_file i_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_addr (instr.rs1),
		.rs2_addr (instr.rs2),
		.wr_addr  (mem_wb_rd),
		.wr_en    (mem_wb_valid && mem_wb_writes),
		.wr_data  (mem_wb_result),
		.rs1_data (id_rs1),
		.rs2_data (id_rs2)
	);

	fwd_unit i_fwd_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_instr   (id_ex_instr),
		.mem_valid  (ex_mem_valid),
		.mem_rd     (ex_mem_rd),
		.mem_writes (ex_mem_writes),
		.mem_opcode (ex_mem_opcode),
		.wb_valid   (mem_wb_valid),
		.wb_rd      (mem_wb_rd),
		.wb_writes  (mem_wb_writes),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b)
	);

	ex_mux i_ex_mux (
		.instr           (id_ex_instr),
		.pc              (id_ex_pc),
		.rs1             (id_ex_rs1),
		.rs2             (id_ex_rs2),
		.imm             (id_ex_imm),
		.ex_ex_fwd_data  (ex_mem_alu),
		.mem_ex_fwd_data (mem_wb_result),
		.fwd_a           (fwd_a),
		.fwd_b           (fwd_b),
		.a_out           (alu_a),
		.b_out           (alu_b),
		.store_data      (ex_store_data)
	);

	alu i_alu (
		.alu_op (id_ex_alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result)
	);

	assign mem_wr_en   = ex_mem_valid && (ex_mem_opcode == defines::STORE);
	assign mem_wr_data = ex_mem_mm_fwd ? mem_wb_result : ex_mem_store; // load just ahead
	assign mem_result  = (ex_mem_opcode == defines::LOAD) ? mem_rd_data : ex_mem_alu;

	data_mem i_data_mem (
		.clk     (clk),
		.addr    (ex_mem_alu),
		.wr_en   (mem_wr_en),
		.wr_data (mem_wr_data),
		.rd_data (mem_rd_data)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex_valid  <= 1'b0;
			id_ex_instr  <= '0;
			ex_mem_valid <= 1'b0;
			mem_wb_valid <= 1'b0;
			wb_valid     <= 1'b0;
		end else begin
			id_ex_valid  <= instr_valid;
			id_ex_instr  <= instr_valid ? instr : '0; // bubble carries a null word
			ex_mem_valid <= id_ex_valid;
			mem_wb_valid <= ex_mem_valid;
			wb_valid     <= mem_wb_valid && mem_wb_writes;
		end
	end

	always_ff @(posedge clk) begin
		id_ex_pc      <= pc;
		id_ex_rs1     <= id_rs1;
		id_ex_rs2     <= id_rs2;
		id_ex_imm     <= id_imm;
		id_ex_alu_op  <= id_alu_op;
		id_ex_rd      <= instr.rd;
		id_ex_writes  <= id_writes;

		ex_mem_opcode <= id_ex_instr.opcode;
		ex_mem_rd     <= id_ex_rd;
		ex_mem_alu    <= alu_result;
		ex_mem_store  <= ex_store_data;
		ex_mem_writes <= id_ex_writes;
		ex_mem_mm_fwd <= (fwd_b == defines::MEM_MEM_FWD_SEL);

		mem_wb_rd     <= ex_mem_rd;
		mem_wb_result <= mem_result;
		mem_wb_writes <= ex_mem_writes;

		wb_rd         <= mem_wb_rd;
		wb_data       <= mem_wb_result;
	end

endmodule

//--- source/fwd_unit.sv
`timescale 1ns/1ps

module fwd_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  defines::instr_t    ex_instr,
	input  logic               mem_valid,
	input  defines::reg_addr_t mem_rd,
	input  logic               mem_writes,
	input  defines::opcode_t   mem_opcode,
	input  logic               wb_valid,
	input  defines::reg_addr_t wb_rd,
	input  logic               wb_writes,
	output defines::fwd_sel_t  fwd_a,
	output defines::fwd_sel_t  fwd_b
);

	logic mem_load, ex_store;
	logic mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;

	assign mem_load  = mem_valid && mem_writes && (mem_opcode == defines::LOAD);
	assign ex_store  = (ex_instr.opcode == defines::STORE);
	assign mem_hit_a = mem_valid && mem_writes && (mem_rd == ex_instr.rs1);
	assign mem_hit_b = mem_valid && mem_writes && (mem_rd == ex_instr.rs2);
	assign wb_hit_a  = wb_valid && wb_writes && (wb_rd == ex_instr.rs1);
	assign wb_hit_b  = wb_valid && wb_writes && (wb_rd == ex_instr.rs2);

	always_comb begin : sel_a
		if (mem_hit_a)     fwd_a = defines::EX_EX_FWD_SEL;
		else if (wb_hit_a) fwd_a = defines::MEM_EX_FWD_SEL;
		else               fwd_a = defines::RS_SEL;
	end

	always_comb begin : sel_b
		if (ex_store && mem_load && ex_instr.rs2 != '0 && mem_rd == ex_instr.rs2)
			fwd_b = defines::MEM_MEM_FWD_SEL; // data patched in mem stage
		else if (mem_hit_b)
			fwd_b = defines::EX_EX_FWD_SEL;
		else if (wb_hit_b)
			fwd_b = defines::MEM_EX_FWD_SEL;
		else
			fwd_b = defines::RS_SEL;
	end

	// no interlock, so a load result is never consumed by the next op in ex
	a_load_use: assert property (@(posedge clk) disable iff (!rst_n)
		mem_load |-> (ex_instr.rs1 != mem_rd) && (ex_store || ex_instr.rs2 != mem_rd))
		else $error("load-use hazard on x%0d", mem_rd);

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  defines::reg_addr_t rs1_addr,
	input  defines::reg_addr_t rs2_addr,
	input  defines::reg_addr_t wr_addr,
	input  logic               wr_en,
	input  defines::data_t     wr_data,
	output defines::data_t     rs1_data,
	output defines::data_t     rs2_data
);

	defines::data_t regs [32];
	logic wr_live;

	assign wr_live = wr_en && (wr_addr != '0); // x0 stays zero

	// same-cycle write shows through
	assign rs1_data = (wr_live && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
	assign rs2_data = (wr_live && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < $size(regs); i++) begin
				regs[i] <= defines::NULL;
			end
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule
